//--- include/simd_alu_cfg.svh
// simd alu configuration
`ifndef SIMD_ALU_CFG_SVH
`define SIMD_ALU_CFG_SVH

// full data word
`define ALU_WIDTH 32

// smallest lane is one byte
`define LANE_WIDTH 8

// byte lanes per word
// also the width of every per-lane mask
`define LANE_COUNT 4

// entries in the decoded operation queue
`define OP_QUEUE_DEPTH 4

`endif

//--- hdl/simd_alu_pkg.sv
// simd alu types
`include "simd_alu_cfg.svh"

package simd_alu_pkg;

  // operations accepted on the request side
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB,
    ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_EQ, ALU_NE, ALU_LTS, ALU_LTU, ALU_GES, ALU_GEU,
    ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU,
    ALU_RELU
  } alu_opcode_e;

  // lane split of the 32-bit word
  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

  // result class chosen at decode
  typedef enum logic [2:0] {
    RES_ADD, RES_LOGIC, RES_SHIFT, RES_CMP, RES_MINMAX, RES_RELU
  } res_sel_e;

  // one decoded operation as it sits in the queue
  typedef struct packed {
    alu_opcode_e           opcode;
    vec_mode_e             vec_mode;
    res_sel_e              res_sel;
    logic                  negate;
    logic                  cmp_signed;
    logic                  shift_left;
    logic                  shift_arith;
    logic                  do_min;
    logic [`ALU_WIDTH-1:0] operand_a;
    logic [`ALU_WIDTH-1:0] operand_b;
  } alu_entry_t;

endpackage

//--- hdl/lane_adder.sv
// partitioned simd adder
`timescale 1ns/1ps
`include "simd_alu_cfg.svh"

module lane_adder
  import simd_alu_pkg::*;
(
  input  logic [`ALU_WIDTH-1:0] op_a_i,
  input  logic [`ALU_WIDTH-1:0] op_b_i,
  input  logic                  negate_i,
  input  vec_mode_e             vec_mode_i,
  output logic [`ALU_WIDTH-1:0] sum_o
);

  localparam int LW = `LANE_WIDTH;
  // one carry slot below every byte
  localparam int SW = `LANE_COUNT * (LW + 1);

  logic [`ALU_WIDTH-1:0]  op_b;
  logic [`LANE_COUNT-1:0] lane_edge;
  logic [SW-1:0]          in_a;
  logic [SW-1:0]          in_b;
  logic [SW-1:0]          sum_wide;

  // subtract as a + ~b + 1 in every lane
  assign op_b = negate_i ? ~op_b_i : op_b_i;

  genvar k;
  generate
    for (k = 0; k < `LANE_COUNT; k++) begin : gen_slot
      if (k == 0) begin : gen_low
        // lowest byte always starts a lane
        assign lane_edge[k] = 1'b1;
      end else begin : gen_upper
        assign lane_edge[k] = (vec_mode_i == VEC_MODE8) ||
                              ((vec_mode_i == VEC_MODE16) && (k % 2 == 0));
      end

      // inside a lane the slot is 1/0 and passes the carry through
      // at an edge 0/0 kills the carry and 1/1 injects the subtract one
      assign in_a[k*(LW+1)] = !(lane_edge[k] && !negate_i);
      assign in_b[k*(LW+1)] = lane_edge[k] && negate_i;

      assign in_a[k*(LW+1)+1+:LW] = op_a_i[LW*k+:LW];
      assign in_b[k*(LW+1)+1+:LW] = op_b[LW*k+:LW];

      // strip the slots again
      assign sum_o[LW*k+:LW] = sum_wide[k*(LW+1)+1+:LW];
    end
  endgenerate

  // carry out of the top lane is dropped
  assign sum_wide = in_a + in_b;

endmodule

//--- hdl/lane_shifter.sv
// per-lane simd shifter
`timescale 1ns/1ps
`include "simd_alu_cfg.svh"

module lane_shifter
  import simd_alu_pkg::*;
(
  input  logic [`ALU_WIDTH-1:0] op_a_i,
  input  logic [`ALU_WIDTH-1:0] amt_i,
  input  logic                  shift_left_i,
  input  logic                  shift_arith_i,
  input  vec_mode_e             vec_mode_i,
  output logic [`ALU_WIDTH-1:0] result_o
);

  localparam int W  = `ALU_WIDTH;
  localparam int LW = `LANE_WIDTH;
  localparam int HW = 2 * LW;

  logic [W-1:0]                 op_a_rev;
  logic [W-1:0]                 amt_left;
  logic [W-1:0]                 src;
  logic [W-1:0]                 amt;
  logic                         arith;
  logic [W:0]                   sh_word;
  logic [1:0][HW:0]             sh_half;
  logic [`LANE_COUNT-1:0][LW:0] sh_byte;
  logic [W-1:0]                 right_res;
  logic [W-1:0]                 right_res_rev;

  // left shift is a right shift on the bit-reversed word
  genvar j;
  generate
    for (j = 0; j < W; j++) begin : gen_rev
      assign op_a_rev[j]      = op_a_i[W-1-j];
      assign right_res_rev[j] = right_res[W-1-j];
    end
  endgenerate

  // reversal also swaps lane order, so the amounts swap with it
  always_comb begin
    case (vec_mode_i)
      VEC_MODE16: amt_left = {amt_i[HW-1:0], amt_i[W-1:HW]};
      VEC_MODE8:  amt_left = {amt_i[LW-1:0], amt_i[2*LW-1:LW],
                              amt_i[3*LW-1:2*LW], amt_i[4*LW-1:3*LW]};
      default:    amt_left = amt_i;
    endcase
  end

  assign src   = shift_left_i ? op_a_rev : op_a_i;
  assign amt   = shift_left_i ? amt_left : amt_i;
  // left shifts fill with zero
  assign arith = shift_arith_i && !shift_left_i;

  // one extra top bit carries the fill
  assign sh_word = $signed({arith & src[W-1], src}) >>> amt[$clog2(W)-1:0];

  generate
    for (j = 0; j < 2; j++) begin : gen_half
      assign sh_half[j] = $signed({arith & src[HW*j+HW-1], src[HW*j+:HW]})
                          >>> amt[HW*j+:$clog2(HW)];
    end
    for (j = 0; j < `LANE_COUNT; j++) begin : gen_byte
      assign sh_byte[j] = $signed({arith & src[LW*j+LW-1], src[LW*j+:LW]})
                          >>> amt[LW*j+:$clog2(LW)];
    end
  endgenerate

  always_comb begin
    case (vec_mode_i)
      VEC_MODE16: right_res = {sh_half[1][HW-1:0], sh_half[0][HW-1:0]};
      VEC_MODE8:  right_res = {sh_byte[3][LW-1:0], sh_byte[2][LW-1:0],
                               sh_byte[1][LW-1:0], sh_byte[0][LW-1:0]};
      default:    right_res = sh_word[W-1:0];
    endcase
  end

  assign result_o = shift_left_i ? right_res_rev : right_res;

endmodule

//--- hdl/lane_compare.sv
// per-lane compare and min/max
`timescale 1ns/1ps
`include "simd_alu_cfg.svh"

module lane_compare
  import simd_alu_pkg::*;
(
  input  logic [`ALU_WIDTH-1:0]  op_a_i,
  input  logic [`ALU_WIDTH-1:0]  op_b_i,
  input  logic                   cmp_signed_i,
  input  logic                   do_min_i,
  input  vec_mode_e              vec_mode_i,
  output logic [`LANE_COUNT-1:0] is_equal_o,
  output logic [`LANE_COUNT-1:0] is_greater_o,
  output logic [`ALU_WIDTH-1:0]  minmax_o
);

  localparam int LW = `LANE_WIDTH;

  logic [`LANE_COUNT-1:0] lane_top;
  logic [`LANE_COUNT-1:0] sign_byte;
  logic [`LANE_COUNT-1:0] eq_byte;
  logic [`LANE_COUNT-1:0] gt_byte;
  logic [`LANE_COUNT-1:0] sel_a;

  // bytes that hold the sign bit of their lane
  always_comb begin
    case (vec_mode_i)
      VEC_MODE8:  lane_top = 4'b1111;
      VEC_MODE16: lane_top = 4'b1010;
      default:    lane_top = 4'b1000;
    endcase
  end

  assign sign_byte = lane_top & {`LANE_COUNT{cmp_signed_i}};

  genvar i;
  generate
    for (i = 0; i < `LANE_COUNT; i++) begin : gen_byte
      assign eq_byte[i] = (op_a_i[LW*i+:LW] == op_b_i[LW*i+:LW]);
      // lower bytes of a lane always compare unsigned
      assign gt_byte[i] = $signed({op_a_i[LW*i+LW-1] & sign_byte[i], op_a_i[LW*i+:LW]}) >
                          $signed({op_b_i[LW*i+LW-1] & sign_byte[i], op_b_i[LW*i+:LW]});

      // max keeps a when greater, min flips the pick
      assign sel_a[i]           = is_greater_o[i] ^ do_min_i;
      assign minmax_o[LW*i+:LW] = sel_a[i] ? op_a_i[LW*i+:LW] : op_b_i[LW*i+:LW];
    end
  endgenerate

  // merge byte results upwards from the top byte of each lane
  always_comb begin
    is_equal_o   = {`LANE_COUNT{&eq_byte}};
    is_greater_o = {`LANE_COUNT{gt_byte[3] | (eq_byte[3] & (gt_byte[2] |
                   (eq_byte[2] & (gt_byte[1] | (eq_byte[1] & gt_byte[0])))))}};

    case (vec_mode_i)
      VEC_MODE16: begin
        is_equal_o[1:0]   = {2{&eq_byte[1:0]}};
        is_equal_o[3:2]   = {2{&eq_byte[3:2]}};
        is_greater_o[1:0] = {2{gt_byte[1] | (eq_byte[1] & gt_byte[0])}};
        is_greater_o[3:2] = {2{gt_byte[3] | (eq_byte[3] & gt_byte[2])}};
      end
      VEC_MODE8: begin
        is_equal_o   = eq_byte;
        is_greater_o = gt_byte;
      end
      default: ;
    endcase
  end

endmodule

//--- hdl/alu_issue.sv
// alu request issue and decode
`timescale 1ns/1ps
`include "simd_alu_cfg.svh"

module alu_issue
  import simd_alu_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  alu_opcode_e           op_i,
  input  vec_mode_e             vec_mode_i,
  input  logic [`ALU_WIDTH-1:0] operand_a_i,
  input  logic [`ALU_WIDTH-1:0] operand_b_i,
  output logic                  iss_valid_o,
  input  logic                  iss_ready_i,
  output alu_entry_t            iss_entry_o
);

  alu_entry_t dec_entry;
  logic       req_fire;

  // take a new request when empty or when the held one drains now
  assign req_ready_o = !iss_valid_o || iss_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;

  // decode straight from the incoming opcode
  always_comb begin
    dec_entry.opcode      = op_i;
    dec_entry.vec_mode    = vec_mode_i;
    dec_entry.operand_a   = operand_a_i;
    dec_entry.operand_b   = operand_b_i;
    dec_entry.negate      = (op_i == ALU_SUB);
    // signed compare also drives signed min/max
    dec_entry.cmp_signed  = (op_i == ALU_LTS) || (op_i == ALU_GES) ||
                            (op_i == ALU_MIN) || (op_i == ALU_MAX);
    dec_entry.shift_left  = (op_i == ALU_SLL);
    dec_entry.shift_arith = (op_i == ALU_SRA);
    dec_entry.do_min      = (op_i == ALU_MIN) || (op_i == ALU_MINU);

    case (op_i)
      ALU_AND, ALU_OR, ALU_XOR:                      dec_entry.res_sel = RES_LOGIC;
      ALU_SLL, ALU_SRL, ALU_SRA:                     dec_entry.res_sel = RES_SHIFT;
      ALU_EQ, ALU_NE, ALU_LTS, ALU_LTU, ALU_GES, ALU_GEU: dec_entry.res_sel = RES_CMP;
      ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU:          dec_entry.res_sel = RES_MINMAX;
      ALU_RELU:                                      dec_entry.res_sel = RES_RELU;
      default:                                       dec_entry.res_sel = RES_ADD;
    endcase
  end

  // one-entry holding register towards the queue
  always_ff @(posedge clk) begin
    if (reset_i) begin
      iss_valid_o <= 1'b0;
    end else if (req_fire) begin
      iss_valid_o <= 1'b1;
    end else if (iss_ready_i) begin
      iss_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      iss_entry_o <= dec_entry;
    end
  end

  // the requester must present a defined opcode with every valid
  a_op_known : assert property (@(posedge clk) disable iff (reset_i)
    req_valid_i |-> !$isunknown(op_i))
    else $error("alu_issue: undefined opcode on a valid request");

endmodule

//--- hdl/op_queue.sv
// decoded operation queue
`timescale 1ns/1ps
`include "simd_alu_cfg.svh"

module op_queue
  import simd_alu_pkg::*;
(
  input  logic       clk,
  input  logic       reset_i,
  input  logic       wr_valid_i,
  output logic       wr_ready_o,
  input  alu_entry_t wr_entry_i,
  output logic       rd_valid_o,
  input  logic       rd_ready_i,
  output alu_entry_t rd_entry_o
);

  localparam int DEPTH = `OP_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  alu_entry_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             wr_fire;
  logic             rd_fire;

  // circular pointer step
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    ptr_next = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wr_ready_o = (count_q != CNT_W'(DEPTH));
  assign rd_valid_o = (count_q != '0);
  assign wr_fire    = wr_valid_i && wr_ready_o;
  assign rd_fire    = rd_valid_o && rd_ready_i;
  // head entry goes out without a register stage
  assign rd_entry_o = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (rd_fire) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      // push and pop together leave the count alone
      case ({wr_fire, rd_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_ptr_q] <= wr_entry_i;
    end
  end

  a_count_bound : assert property (@(posedge clk) disable iff (reset_i)
    count_q <= CNT_W'(DEPTH))
    else $error("op_queue: occupancy above depth");

endmodule

//--- hdl/alu_execute.sv
// alu execute stage
`timescale 1ns/1ps
`include "simd_alu_cfg.svh"

module alu_execute
  import simd_alu_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  exe_valid_i,
  output logic                  exe_ready_o,
  input  alu_entry_t            exe_entry_i,
  output logic                  res_valid_o,
  input  logic                  res_ready_i,
  output logic [`ALU_WIDTH-1:0] result_o,
  output logic                  cmp_flag_o
);

  localparam int LW = `LANE_WIDTH;

  logic [`ALU_WIDTH-1:0]  op_a;
  logic [`ALU_WIDTH-1:0]  op_b;
  logic [`ALU_WIDTH-1:0]  add_res;
  logic [`ALU_WIDTH-1:0]  shift_res;
  logic [`ALU_WIDTH-1:0]  minmax_res;
  logic [`ALU_WIDTH-1:0]  logic_res;
  logic [`ALU_WIDTH-1:0]  relu_res;
  logic [`ALU_WIDTH-1:0]  cmp_mask;
  logic [`ALU_WIDTH-1:0]  result_d;
  logic [`LANE_COUNT-1:0] is_equal;
  logic [`LANE_COUNT-1:0] is_greater;
  logic [`LANE_COUNT-1:0] cmp_res;
  logic [`LANE_COUNT-1:0] relu_neg;
  logic                   cmp_flag_d;
  logic                   exe_fire;

  assign op_a = exe_entry_i.operand_a;
  assign op_b = exe_entry_i.operand_b;

  // pop whenever the output register is free or being drained
  assign exe_ready_o = !res_valid_o || res_ready_i;
  assign exe_fire    = exe_valid_i && exe_ready_o;

  ////////////////////////////////////////////////////////////
  // lane datapaths
  ////////////////////////////////////////////////////////////

  lane_adder u_adder (
    .op_a_i     (op_a),
    .op_b_i     (op_b),
    .negate_i   (exe_entry_i.negate),
    .vec_mode_i (exe_entry_i.vec_mode),
    .sum_o      (add_res)
  );

  // operand b carries the per-lane shift amounts
  lane_shifter u_shifter (
    .op_a_i        (op_a),
    .amt_i         (op_b),
    .shift_left_i  (exe_entry_i.shift_left),
    .shift_arith_i (exe_entry_i.shift_arith),
    .vec_mode_i    (exe_entry_i.vec_mode),
    .result_o      (shift_res)
  );

  lane_compare u_compare (
    .op_a_i       (op_a),
    .op_b_i       (op_b),
    .cmp_signed_i (exe_entry_i.cmp_signed),
    .do_min_i     (exe_entry_i.do_min),
    .vec_mode_i   (exe_entry_i.vec_mode),
    .is_equal_o   (is_equal),
    .is_greater_o (is_greater),
    .minmax_o     (minmax_res)
  );

  always_comb begin
    case (exe_entry_i.opcode)
      ALU_AND: logic_res = op_a & op_b;
      ALU_OR:  logic_res = op_a | op_b;
      default: logic_res = op_a ^ op_b;
    endcase
  end

  // relation per lane, ge is what remains
  always_comb begin
    case (exe_entry_i.opcode)
      ALU_EQ:           cmp_res = is_equal;
      ALU_NE:           cmp_res = ~is_equal;
      ALU_LTS, ALU_LTU: cmp_res = ~(is_greater | is_equal);
      default:          cmp_res = is_greater | is_equal;
    endcase
  end

  genvar k;
  generate
    for (k = 0; k < `LANE_COUNT; k++) begin : gen_byte
      // sign bit sits in the top byte of the lane holding byte k
      assign relu_neg[k] =
        (exe_entry_i.vec_mode == VEC_MODE8)  ? op_a[LW*k+LW-1] :
        (exe_entry_i.vec_mode == VEC_MODE16) ? op_a[2*LW*(k/2)+2*LW-1] :
                                               op_a[`ALU_WIDTH-1];
      assign relu_res[LW*k+:LW] = relu_neg[k] ? '0 : op_a[LW*k+:LW];
      // a true lane sets all of its bits
      assign cmp_mask[LW*k+:LW] = {LW{cmp_res[k]}};
    end
  endgenerate

  ////////////////////////////////////////////////////////////
  // result select and output register
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (exe_entry_i.res_sel)
      RES_ADD:    result_d = add_res;
      RES_LOGIC:  result_d = logic_res;
      RES_SHIFT:  result_d = shift_res;
      RES_CMP:    result_d = cmp_mask;
      RES_MINMAX: result_d = minmax_res;
      default:    result_d = relu_res;
    endcase
  end

  // flag follows the top lane, only for compares
  assign cmp_flag_d = (exe_entry_i.res_sel == RES_CMP) && cmp_res[`LANE_COUNT-1];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      res_valid_o <= 1'b0;
    end else if (exe_fire) begin
      res_valid_o <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (exe_fire) begin
      result_o   <= result_d;
      cmp_flag_o <= cmp_flag_d;
    end
  end

  // stalled result must hold until taken
  a_result_hold : assert property (@(posedge clk) disable iff (reset_i)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(result_o) && $stable(cmp_flag_o))
    else $error("alu_execute: result changed under back-pressure");

endmodule

//--- hdl/simd_alu_top.sv
// simd alu top level
`timescale 1ns/1ps
`include "simd_alu_cfg.svh"

module simd_alu_top
  import simd_alu_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  alu_opcode_e           op_i,
  input  vec_mode_e             vec_mode_i,
  input  logic [`ALU_WIDTH-1:0] operand_a_i,
  input  logic [`ALU_WIDTH-1:0] operand_b_i,
  output logic                  res_valid_o,
  input  logic                  res_ready_i,
  output logic [`ALU_WIDTH-1:0] result_o,
  output logic                  cmp_flag_o
);

  // issue to queue
  logic       iss_valid;
  logic       iss_ready;
  alu_entry_t iss_entry;

  // queue to execute
  logic       exe_valid;
  logic       exe_ready;
  alu_entry_t exe_entry;

  alu_issue u_issue (
    .clk         (clk),
    .reset_i     (reset_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .op_i        (op_i),
    .vec_mode_i  (vec_mode_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .iss_valid_o (iss_valid),
    .iss_ready_i (iss_ready),
    .iss_entry_o (iss_entry)
  );

  op_queue u_queue (
    .clk        (clk),
    .reset_i    (reset_i),
    .wr_valid_i (iss_valid),
    .wr_ready_o (iss_ready),
    .wr_entry_i (iss_entry),
    .rd_valid_o (exe_valid),
    .rd_ready_i (exe_ready),
    .rd_entry_o (exe_entry)
  );

  alu_execute u_execute (
    .clk         (clk),
    .reset_i     (reset_i),
    .exe_valid_i (exe_valid),
    .exe_ready_o (exe_ready),
    .exe_entry_i (exe_entry),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .result_o    (result_o),
    .cmp_flag_o  (cmp_flag_o)
  );

endmodule

//--- include/alu_tb_tests.svh
// simd alu directed tests
`ifndef ALU_TB_TESTS_SVH
`define ALU_TB_TESTS_SVH

// back-pressure batch is well above the 2 + depth capacity
localparam int BP_OPS  = `OP_QUEUE_DEPTH + 8;
localparam int BP_HOLD = 20;
// one count per queued op, in test order
localparam int TOTAL_OPS = 3 * 8 + 3 * 3 * 3 + 6 * 4 * 3 + 8 * 3 * 3 + BP_OPS;

task automatic queue_all_modes(input alu_opcode_e op, input logic [`ALU_WIDTH-1:0] a,
                               input logic [`ALU_WIDTH-1:0] b);
  queue_op(op, VEC_MODE32, a, b);
  queue_op(op, VEC_MODE16, a, b);
  queue_op(op, VEC_MODE8, a, b);
endtask

task automatic test_reset_state();
  check_flag("res_valid_o", res_valid_o, 1'b0);
  check_flag("req_ready_o", req_ready_o, 1'b1);
endtask

task automatic test_add_sub();
  int r;
  // 8'hff + 1 wraps inside its byte in 8-bit mode
  queue_all_modes(ALU_ADD, 32'h80FF_FFFF, 32'h0101_0101);
  queue_all_modes(ALU_SUB, 32'h0000_0000, 32'h0101_0001);
  for (r = 0; r < 3; r++) begin
    queue_all_modes(ALU_ADD, $urandom, $urandom);
    queue_all_modes(ALU_SUB, $urandom, $urandom);
  end
  run_batch(0);
endtask

task automatic test_shifts();
  alu_opcode_e ops [3];
  int          i;
  int          r;
  ops = '{ALU_SLL, ALU_SRL, ALU_SRA};
  for (i = 0; i < 3; i++) begin
    // a different amount in every byte
    queue_all_modes(ops[i], 32'h8421_F00F, 32'h0703_0501);
    for (r = 0; r < 2; r++) begin
      queue_all_modes(ops[i], $urandom, $urandom);
    end
  end
  run_batch(0);
endtask

task automatic test_compares();
  alu_opcode_e           ops [6];
  logic [`ALU_WIDTH-1:0] same;
  int                    i;
  int                    r;
  ops = '{ALU_EQ, ALU_NE, ALU_LTS, ALU_LTU, ALU_GES, ALU_GEU};
  for (i = 0; i < 6; i++) begin
    // sign bits set so signed and unsigned disagree
    queue_all_modes(ops[i], 32'h8001_7F80, 32'h7F01_8080);
    same = $urandom;
    queue_all_modes(ops[i], same, same);
    for (r = 0; r < 2; r++) begin
      queue_all_modes(ops[i], $urandom, $urandom);
    end
  end
  run_batch(0);
endtask

task automatic test_minmax_logic();
  alu_opcode_e ops [8];
  int          i;
  int          r;
  ops = '{ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU, ALU_RELU, ALU_AND, ALU_OR, ALU_XOR};
  for (i = 0; i < 8; i++) begin
    queue_all_modes(ops[i], 32'h80FF_7F01, 32'h7F01_80FF);
    for (r = 0; r < 2; r++) begin
      queue_all_modes(ops[i], $urandom, $urandom);
    end
  end
  run_batch(0);
endtask

// results held back until the request side stalls
task automatic test_backpressure();
  int i;
  for (i = 0; i < BP_OPS; i++) begin
    queue_op((i % 2 == 1) ? ALU_SUB : ALU_XOR, VEC_MODE16, $urandom, $urandom);
  end
  run_batch(BP_HOLD);
  if (!saw_stall) begin
    abort_run("req_ready_o never dropped while results were held back");
  end
endtask

`endif

//--- verification/tb_simd_alu.sv
// simd alu testbench
`timescale 1ns/1ps
`include "simd_alu_cfg.svh"

module tb_simd_alu
  import simd_alu_pkg::*;
();

  logic                  clk;
  logic                  reset_i;
  logic                  req_valid_i;
  logic                  req_ready_o;
  alu_opcode_e           op_i;
  vec_mode_e             vec_mode_i;
  logic [`ALU_WIDTH-1:0] operand_a_i;
  logic [`ALU_WIDTH-1:0] operand_b_i;
  logic                  res_valid_o;
  logic                  res_ready_i;
  logic [`ALU_WIDTH-1:0] result_o;
  logic                  cmp_flag_o;

  // pending requests of the current batch
  alu_opcode_e           stim_op [$];
  vec_mode_e             stim_mode [$];
  logic [`ALU_WIDTH-1:0] stim_a [$];
  logic [`ALU_WIDTH-1:0] stim_b [$];
  // expected responses in issue order
  logic [`ALU_WIDTH-1:0] exp_res [$];
  logic                  exp_flag [$];
  logic                  exp_cmp [$];
  logic                  saw_stall;
  int                    cycle_count = 0;

  `include "alu_tb_tests.svh"

  // each op may wait for the whole pipeline ahead of it
  localparam int TIMEOUT_CYCLES = TOTAL_OPS * (2 + `OP_QUEUE_DEPTH) + BP_HOLD + 200;

  simd_alu_top dut0 (
    .clk         (clk),
    .reset_i     (reset_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .op_i        (op_i),
    .vec_mode_i  (vec_mode_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .result_o    (result_o),
    .cmp_flag_o  (cmp_flag_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run("timeout: the DUT stopped producing results");
    end
  end

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic logic is_compare(input alu_opcode_e op);
    return op inside {ALU_EQ, ALU_NE, ALU_LTS, ALU_LTU, ALU_GES, ALU_GEU};
  endfunction

  function automatic logic [`ALU_WIDTH-1:0] model_result(
    input  alu_opcode_e           op,
    input  vec_mode_e             mode,
    input  logic [`ALU_WIDTH-1:0] a,
    input  logic [`ALU_WIDTH-1:0] b,
    output logic                  flag
  );
    int                    lw;
    int                    l;
    longint unsigned       mask;
    longint unsigned       ua;
    longint unsigned       ub;
    longint unsigned       lane;
    longint                sa;
    longint                sb;
    logic                  hit;
    logic [63:0]           wide;
    logic [`ALU_WIDTH-1:0] res;
    res  = '0;
    flag = 1'b0;
    lw   = (mode == VEC_MODE8) ? 8 : (mode == VEC_MODE16) ? 16 : 32;
    mask = (64'd1 << lw) - 64'd1;
    for (l = 0; l < `ALU_WIDTH / lw; l++) begin
      ua = a;
      ua = (ua >> (l * lw)) & mask;
      ub = b;
      ub = (ub >> (l * lw)) & mask;
      // two's complement value of each lane
      sa = ua;
      sb = ub;
      if (ua[lw-1]) sa = sa - longint'(mask) - 1;
      if (ub[lw-1]) sb = sb - longint'(mask) - 1;
      hit  = 1'b0;
      lane = 0;
      case (op)
        ALU_ADD:  lane = ua + ub;
        ALU_SUB:  lane = ua - ub;
        ALU_AND:  lane = ua & ub;
        ALU_OR:   lane = ua | ub;
        ALU_XOR:  lane = ua ^ ub;
        // amount is the low bits of the same lane of b
        ALU_SLL:  lane = ua << (ub % lw);
        ALU_SRL:  lane = ua >> (ub % lw);
        ALU_SRA:  lane = sa >>> (ub % lw);
        ALU_EQ:   hit = (ua == ub);
        ALU_NE:   hit = (ua != ub);
        ALU_LTS:  hit = (sa < sb);
        ALU_LTU:  hit = (ua < ub);
        ALU_GES:  hit = (sa >= sb);
        ALU_GEU:  hit = (ua >= ub);
        ALU_MIN:  lane = (sa < sb) ? ua : ub;
        ALU_MINU: lane = (ua < ub) ? ua : ub;
        ALU_MAX:  lane = (sa > sb) ? ua : ub;
        ALU_MAXU: lane = (ua > ub) ? ua : ub;
        // relu zeroes a negative lane
        default:  lane = ua[lw-1] ? 64'd0 : ua;
      endcase
      if (is_compare(op)) begin
        lane = hit ? mask : 64'd0;
        // top lane is visited last
        flag = hit;
      end
      wide = (lane & mask) << (l * lw);
      res  = res | wide[`ALU_WIDTH-1:0];
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_result(input string name, input logic [`ALU_WIDTH-1:0] got,
                              input logic [`ALU_WIDTH-1:0] want);
    if (got !== want) begin
      abort_run($sformatf("Error: %s is %h, expected %h", name, got, want));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      abort_run($sformatf("Error: %s is %h, expected %h", name, got, want));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // request and result sides
  ////////////////////////////////////////////////////////////

  task automatic queue_op(input alu_opcode_e op, input vec_mode_e mode,
                          input logic [`ALU_WIDTH-1:0] a, input logic [`ALU_WIDTH-1:0] b);
    stim_op.push_back(op);
    stim_mode.push_back(mode);
    stim_a.push_back(a);
    stim_b.push_back(b);
  endtask

  task automatic send_requests();
    logic [`ALU_WIDTH-1:0] want;
    logic                  want_flag;
    while (stim_op.size() > 0) begin
      @(negedge clk);
      req_valid_i = 1'b1;
      op_i        = stim_op[0];
      vec_mode_i  = stim_mode[0];
      operand_a_i = stim_a[0];
      operand_b_i = stim_b[0];
      // ready comes from registers only, settled at the falling edge
      while (!req_ready_o) begin
        saw_stall = 1'b1;
        @(negedge clk);
      end
      want = model_result(op_i, vec_mode_i, operand_a_i, operand_b_i, want_flag);
      exp_res.push_back(want);
      exp_flag.push_back(want_flag);
      exp_cmp.push_back(is_compare(op_i));
      void'(stim_op.pop_front());
      void'(stim_mode.pop_front());
      void'(stim_a.pop_front());
      void'(stim_b.pop_front());
    end
    @(negedge clk);
    req_valid_i = 1'b0;
  endtask

  task automatic collect_results(input int count, input int hold_cycles);
    int                    seen;
    int                    hold;
    logic [`ALU_WIDTH-1:0] want;
    logic                  want_flag;
    logic                  want_cmp;
    seen = 0;
    hold = hold_cycles;
    while (seen < count) begin
      @(negedge clk);
      res_ready_i = (hold == 0);
      if (hold > 0) hold--;
      if (res_valid_o && res_ready_i) begin
        if (exp_res.size() == 0) begin
          abort_run("a result arrived with no request outstanding");
        end else begin
          want      = exp_res.pop_front();
          want_flag = exp_flag.pop_front();
          want_cmp  = exp_cmp.pop_front();
          check_result("result_o", result_o, want);
          if (want_cmp) check_flag("cmp_flag_o", cmp_flag_o, want_flag);
          seen++;
        end
      end
    end
  endtask

  // issue the queued ops while draining results in order
  task automatic run_batch(input int hold_cycles);
    int n;
    n         = stim_op.size();
    saw_stall = 1'b0;
    fork
      send_requests();
      collect_results(n, hold_cycles);
    join
    @(negedge clk);
    if (res_valid_o) abort_run("an extra result appeared after the batch drained");
  endtask

  initial begin
    void'($urandom(32'h20821beb));
    reset_i     = 1'b1;
    req_valid_i = 1'b0;
    op_i        = ALU_ADD;
    vec_mode_i  = VEC_MODE32;
    operand_a_i = '0;
    operand_b_i = '0;
    res_ready_i = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;

    test_reset_state();
    test_add_sub();
    test_shifts();
    test_compares();
    test_minmax_logic();
    test_backpressure();

    $display("all tests passed");
    $finish;
  end

endmodule

//--- files.f
+incdir+include
hdl/simd_alu_pkg.sv
hdl/lane_adder.sv
hdl/lane_shifter.sv
hdl/lane_compare.sv
hdl/alu_issue.sv
hdl/op_queue.sv
hdl/alu_execute.sv
hdl/simd_alu_top.sv
verification/tb_simd_alu.sv

//--- run.sh
#!/bin/sh
# build the testbench with verilator, run it, and look for the pass line

verilator --binary --timing --assert -Wno-fatal --top-module tb_simd_alu -f files.f \
  && ./obj_dir/Vtb_simd_alu | grep "all tests passed" \
  || { echo "simulation did not pass"; exit 1; }
